//--- ttc_timer_top.f
source/ttc_pkg.sv
source/ttc_reg_decode.sv
source/ttc_prescaler.sv
source/ttc_counter_lite.sv
source/ttc_intr_status.sv
source/ttc_timer_top.sv
testbench/ttc_timer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the timer testbench with Verilator, run it, and scan the log for failure
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --assert -Wno-fatal --top-module ttc_timer_tb \
  -f ttc_timer_top.f -o ttc_timer_sim 2>&1 | tee "$LOG" &&
  ./obj_dir/ttc_timer_sim 2>&1 | tee -a "$LOG" ||
  { echo "Build or simulation error, see $LOG"; exit 1; }

if grep -q "Result: FAILED" "$LOG"
then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi
echo "Simulation finished without failures"
exit 0

//--- testbench/ttc_timer_tb.sv
/* Table-driven testbench for the timer. Each row is a bus access, an idle
   stretch or a stalled read; responses and irq are checked row by row. */
`timescale 1ns/10ps

module ttc_timer_tb;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_IDLE, OP_STALL} op_e;

  // One stimulus row
  typedef struct packed {
    op_e         op;
    logic [3:0]  addr;
    logic [15:0] data;       // Write data, or cycles for idle and stall
    logic [15:0] exp_rdata;
    logic        chk_rdata;
    logic        exp_err;
    logic        exp_irq;
    logic        chk_irq;
    logic [2:0]  test;       // Behavior group 1..6
  } entry_t;

  localparam int IRQ_ANY = 2;  // irq left unchecked
  localparam int N_TESTS = 6;

  logic              pclk14;
  logic              n_p_reset14;
  logic              req_valid;
  logic              req_ready;
  ttc_pkg::bus_req_t req;
  logic              rsp_valid;
  logic              rsp_ready;
  ttc_pkg::bus_rsp_t rsp;
  logic              irq;

  entry_t table_q[$];
  integer seed;
  int     cur_test;
  int     errors;
  int     checks;
  int     failed;
  int     test_errs[1:N_TESTS];
  int     cycles = 0;
  int     limit = 0;          // 0 until the table is built

  ttc_timer_top dut_i (
    .pclk14, .n_p_reset14,
    .req_valid, .req_ready, .req,
    .rsp_valid, .rsp_ready, .rsp,
    .irq
  );

  initial
  begin
    pclk14 = 1'b0;
    forever #10 pclk14 = ~pclk14;  // 20 ns period
  end

  // Watchdog
  always @(posedge pclk14)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit)
    begin
      $display("Timeout: the run hung for %0d cycles waiting on the bus", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // --------------------
  // Table building
  // --------------------
  function automatic void push_entry(op_e op, logic [3:0] addr, logic [15:0] data,
                                     logic [15:0] exp_rdata, logic chk_rdata,
                                     logic exp_err, int irq_exp);
    entry_t e;
    e.op        = op;
    e.addr      = addr;
    e.data      = data;
    e.exp_rdata = exp_rdata;
    e.chk_rdata = chk_rdata;
    e.exp_err   = exp_err;
    e.exp_irq   = (irq_exp == 1);
    e.chk_irq   = (irq_exp != IRQ_ANY);
    e.test      = 3'(cur_test);
    table_q.push_back(e);
  endfunction

  function automatic void add_write(logic [3:0] addr, logic [15:0] data, logic err);
    push_entry(OP_WR, addr, data, 16'h0000, 1'b0, err, IRQ_ANY);
  endfunction

  function automatic void add_read(logic [3:0] addr, logic [15:0] exp, int irq_exp);
    push_entry(OP_RD, addr, 16'h0000, exp, 1'b1, 1'b0, irq_exp);
  endfunction

  function automatic void add_idle(int n, int irq_exp);
    push_entry(OP_IDLE, 4'd0, 16'(n), 16'h0000, 1'b0, 1'b0, irq_exp);
  endfunction

  task automatic build_table();
    logic [15:0] rv[0:3];
    logic [15:0] i3;
    logic [15:0] i4;
    logic [15:0] i5;
    logic [15:0] m1;
    logic [15:0] m2;
    logic [15:0] m3;
    foreach (rv[k])
      rv[k] = 16'($random(seed));
    i3 = 16'($random(seed));
    i4 = 16'd4 + (16'($random(seed)) & 16'h0007);   // Short interval, 4..11
    i5 = 16'd6 + (16'($random(seed)) & 16'h0007);   // 6..13
    m1 = 16'd1 + (16'($random(seed)) % i5);         // Reachable, 1..i5
    m2 = 16'd1 + (16'($random(seed)) % i5);
    m3 = i5 + 16'd1 + (16'($random(seed)) & 16'h00FF);  // Above the interval

    cur_test = 1;  // Reset values
    for (int a = 0; a <= 8; a++)
      add_read(4'(a), (a == 1) ? 16'h0001 : 16'h0000, 0);

    cur_test = 2;  // Read-back and error responses
    add_write(ttc_pkg::ADDR_CLK_CTRL, 16'h001E, 1'b0);  // N = 15, prescaler off
    add_read(ttc_pkg::ADDR_CLK_CTRL, 16'h001E, 0);
    add_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0061, 1'b0);  // Disabled, wave bits
    add_read(ttc_pkg::ADDR_CNTR_CTRL, 16'h0061, 0);
    for (int r = 0; r < 4; r++)
    begin
      add_write(4'(2 + r), rv[r], 1'b0);  // INTERVAL, MATCH_1..3
      add_read(4'(2 + r), rv[r], 0);
    end
    add_write(ttc_pkg::ADDR_INTR_ENABLE, 16'h0015, 1'b0);
    add_read(ttc_pkg::ADDR_INTR_ENABLE, 16'h0015, 0);
    add_write(ttc_pkg::ADDR_INTR_ENABLE, 16'h0000, 1'b0);
    push_entry(OP_RD, 4'd9, 16'h0000, 16'h0000, 1'b1, 1'b1, 0);  // Outside the map
    add_write(ttc_pkg::ADDR_COUNT_VAL, 16'h1234, 1'b1);        // Read only
    add_read(ttc_pkg::ADDR_COUNT_VAL, 16'h0000, 0);

    cur_test = 3;  // Restart while disabled, counting down in interval mode
    add_write(ttc_pkg::ADDR_INTERVAL, i3, 1'b0);
    add_write(ttc_pkg::ADDR_CLK_CTRL, 16'h0001, 1'b0);   // N = 0, every cycle
    add_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0017, 1'b0);  // Restart|dec|intv|dis
    add_read(ttc_pkg::ADDR_COUNT_VAL, i3, 0);
    add_read(ttc_pkg::ADDR_CNTR_CTRL, 16'h0007, 0);      // Restart gone

    cur_test = 4;  // Interval event and interrupt
    add_write(ttc_pkg::ADDR_INTERVAL, i4, 1'b0);
    add_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0012, 1'b0);  // Up, interval, restart
    add_idle(2 * (i4 + 1) + 4, 0);                       // Nothing enabled yet
    add_write(ttc_pkg::ADDR_INTR_ENABLE, 16'h0001, 1'b0);
    add_read(ttc_pkg::ADDR_INTR_STATUS, 16'h0001, 1);
    add_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0003, 1'b0);  // Stop counting
    push_entry(OP_RD, ttc_pkg::ADDR_INTR_STATUS, 16'h0000, 16'h0000, 1'b0, 1'b0, IRQ_ANY);
    add_read(ttc_pkg::ADDR_INTR_STATUS, 16'h0000, 0);
    add_idle(2, 0);

    cur_test = 5;  // Two matches inside the interval, one beyond it
    add_write(ttc_pkg::ADDR_INTERVAL, i5, 1'b0);
    add_write(ttc_pkg::ADDR_MATCH_1, m1, 1'b0);
    add_write(ttc_pkg::ADDR_MATCH_2, m2, 1'b0);
    add_write(ttc_pkg::ADDR_MATCH_3, m3, 1'b0);
    add_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h001A, 1'b0);  // Match, interval, restart
    add_idle(2 * (i5 + 1) + 4, 1);
    add_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h000B, 1'b0);
    add_read(ttc_pkg::ADDR_INTR_STATUS, 16'h000D, 1);    // Match 2, match 1, interval
    add_read(ttc_pkg::ADDR_INTR_STATUS, 16'h0000, 0);

    cur_test = 6;  // Response held back for 5 cycles
    push_entry(OP_STALL, ttc_pkg::ADDR_MATCH_3, 16'd5, m3, 1'b1, 1'b0, 0);
    add_read(ttc_pkg::ADDR_MATCH_1, m1, 0);
  endtask

  // --------------------
  // Checking
  // --------------------
  task automatic count_error(input int t);
    errors++;
    test_errs[t]++;
  endtask

  task automatic check_response(input entry_t e);
    checks++;
    assert (rsp.err === e.exp_err)
    else
    begin
      count_error(e.test);
      $display("Error at %0t ns: addr %0d err %b, expected %b", $time, e.addr, rsp.err,
               e.exp_err);
    end
    if (e.chk_rdata)
    begin
      checks++;
      assert (rsp.rdata === e.exp_rdata)
      else
      begin
        count_error(e.test);
        $display("Error at %0t ns: addr %0d rdata %h, expected %h", $time, e.addr,
                 rsp.rdata, e.exp_rdata);
      end
    end
    if (e.chk_irq)
    begin
      checks++;
      assert (irq === e.exp_irq)
      else
      begin
        count_error(e.test);
        $display("Error at %0t ns: irq %b, expected %b", $time, irq, e.exp_irq);
      end
    end
  endtask

  // One bus transaction; stall holds rsp_ready low that many cycles
  task automatic run_access(input entry_t e, input int stall);
    ttc_pkg::bus_rsp_t held;
    @(posedge pclk14);
    #1;
    req_valid = 1'b1;
    req.write = (e.op == OP_WR);
    req.addr  = e.addr;
    req.wdata = (e.op == OP_WR) ? e.data : 16'h0000;
    rsp_ready = (stall == 0);
    @(negedge pclk14);
    while (!req_ready)
      @(negedge pclk14);         // Accepted on the next rising edge
    @(posedge pclk14);
    #1;
    req_valid = 1'b0;
    @(negedge pclk14);
    while (!rsp_valid)
      @(negedge pclk14);
    check_response(e);
    held = rsp;
    for (int k = 0; k < stall; k++)
    begin
      @(negedge pclk14);
      checks++;
      assert (!req_ready && rsp_valid && rsp === held)
      else
      begin
        count_error(e.test);
        $display("Error at %0t ns: under back-pressure req_ready %b, rsp %h, held %h",
                 $time, req_ready, rsp, held);
      end
    end
    if (stall > 0)
    begin
      @(posedge pclk14);
      #1;
      rsp_ready = 1'b1;          // Release
    end
    @(posedge pclk14);           // Response taken here
  endtask

  task automatic run_idle(input entry_t e);
    repeat (e.data) @(posedge pclk14);
    @(negedge pclk14);
    if (e.chk_irq)
    begin
      checks++;
      assert (irq === e.exp_irq)
      else
      begin
        count_error(e.test);
        $display("Error at %0t ns: irq %b after idle, expected %b", $time, irq, e.exp_irq);
      end
    end
  endtask

  function automatic string test_name(input int t);
    case (t)
      1:       return "reset values";
      2:       return "register read-back";
      3:       return "down-count restart";
      4:       return "interval interrupt";
      5:       return "match events";
      default: return "back-pressure";
    endcase
  endfunction

  task automatic report_test(input int t);
    if (test_errs[t] == 0)
      $display("Test %0d %s: ok", t, test_name(t));
    else
      $display("Test %0d %s: %0d errors", t, test_name(t), test_errs[t]);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    int prev;
    int budget;
    $timeformat(-9, 0, "", 0);   // Times print in ns
    seed   = 94283;
    errors = 0;
    checks = 0;
    failed = 0;
    foreach (test_errs[t])
      test_errs[t] = 0;
    n_p_reset14 = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    rsp_ready   = 1'b1;

    build_table();
    budget = 5;                  // Reset cycles
    foreach (table_q[i])
    begin
      budget += 20;
      if (table_q[i].op == OP_IDLE || table_q[i].op == OP_STALL)
        budget += int'(table_q[i].data);
    end
    limit = budget;

    repeat (5) @(posedge pclk14);
    #1 n_p_reset14 = 1'b1;

    prev = 0;
    foreach (table_q[i])
    begin
      if (prev != 0 && table_q[i].test != prev)
        report_test(prev);       // Group just finished
      prev = table_q[i].test;
      case (table_q[i].op)
        OP_IDLE:  run_idle(table_q[i]);
        OP_STALL: run_access(table_q[i], int'(table_q[i].data));
        default:  run_access(table_q[i], 0);
      endcase
    end
    report_test(prev);

    foreach (test_errs[t])
      if (test_errs[t] != 0)
        failed++;
    $display("Summary: %0d of %0d tests failed, %0d checks, %0d errors", failed, N_TESTS,
             checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- source/ttc_timer_top.sv
/* Timer top level. Joins the register decode, prescaler, counter and
   interrupt status blocks; the host sees one request/response port. */
`timescale 1ns/10ps

module ttc_timer_top #(
  parameter int PRESCALE_W = ttc_pkg::PRESCALE_W_DEF
) (
  input  logic              pclk14,
  input  logic              n_p_reset14,
  input  logic              req_valid,
  output logic              req_ready,
  input  ttc_pkg::bus_req_t req,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output ttc_pkg::bus_rsp_t rsp,
  output logic              irq
);

  ttc_pkg::reg_wr_t    wr;
  logic                status_rd;
  logic                count_en;
  logic [15:0]         clk_ctrl;
  ttc_pkg::cntr_ctrl_t cntr_ctrl;
  logic [15:0]         interval;
  logic [15:0]         match_1;
  logic [15:0]         match_2;
  logic [15:0]         match_3;
  logic [15:0]         count_val;
  ttc_pkg::cnt_event_t events;
  ttc_pkg::cnt_event_t status;
  ttc_pkg::cnt_event_t enable;

  // --------------------
  // Decode
  // --------------------
  ttc_reg_decode decode_i (
    .pclk14, .n_p_reset14,
    .req_valid, .req_ready, .req,
    .rsp_valid, .rsp_ready, .rsp,
    .wr, .status_rd,
    .clk_ctrl, .cntr_ctrl, .interval,
    .match_1, .match_2, .match_3,
    .count_val, .status, .enable
  );

  // --------------------
  // Execute
  // --------------------
  ttc_prescaler #(.PRESCALE_W(PRESCALE_W)) prescaler_i (
    .pclk14, .n_p_reset14, .wr,
    .clk_ctrl, .count_en
  );

  ttc_counter_lite counter_i (
    .pclk14, .n_p_reset14, .wr, .count_en,
    .cntr_ctrl, .interval, .match_1, .match_2, .match_3,
    .count_val, .events
  );

  // Result
  ttc_intr_status status_i (
    .pclk14, .n_p_reset14, .wr, .events, .status_rd,
    .status, .enable, .irq
  );

endmodule

//--- source/ttc_intr_status.sv
/* Sticky event status with clear-on-read, the interrupt enable mask and the
   registered interrupt line. */
`timescale 1ns/10ps

module ttc_intr_status (
  input  logic                pclk14,
  input  logic                n_p_reset14,
  input  ttc_pkg::reg_wr_t    wr,
  input  ttc_pkg::cnt_event_t events,     // Counter pulses
  input  logic                status_rd,  // Host read of INTR_STATUS
  output ttc_pkg::cnt_event_t status,
  output ttc_pkg::cnt_event_t enable,
  output logic                irq
);

  ttc_pkg::cnt_event_t status_nxt;
  logic                irq_nxt;

  // --------------------
  // Status
  // --------------------
  // Read clears, but a same-cycle event wins
  assign status_nxt = (status_rd ? ttc_pkg::cnt_event_t'('0) : status) | events;

  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
      status <= '0;
    else
      status <= status_nxt;
  end

  // Enable mask, low 5 bits of the write data
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
      enable <= '0;
    else if (wr.intr_enable)
      enable <= ttc_pkg::cnt_event_t'(wr.data[4:0]);
  end

  // --------------------
  // Interrupt line
  // --------------------
  assign irq_nxt = |(status & enable);

  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
      irq <= 1'b0;
    else
      irq <= irq_nxt;  // One cycle behind status
  end

  // irq has an enabled, pending bit behind it, except just after a clear or mask change
  a_irq_cause: assert property (
    @(posedge pclk14) disable iff (!n_p_reset14)
    irq |-> (|(status & enable)) || $past(status_rd) || $past(wr.intr_enable));

endmodule

//--- source/ttc_counter_lite.sv
/* One counter channel with control, interval and three match registers.
   Counts up or down on count_en, over the full range or a programmed
   interval, and raises interval, overflow and match event pulses. */
`timescale 1ns/10ps

module ttc_counter_lite (
  input  logic                pclk14,
  input  logic                n_p_reset14,
  input  ttc_pkg::reg_wr_t    wr,
  input  logic                count_en,     // From the prescaler
  output ttc_pkg::cntr_ctrl_t cntr_ctrl,
  output logic [15:0]         interval,
  output logic [15:0]         match_1,
  output logic [15:0]         match_2,
  output logic [15:0]         match_3,
  output logic [15:0]         count_val,
  output ttc_pkg::cnt_event_t events
);

  logic        counting;      // First enabled count seen since restart
  logic        restart_pend;  // Restart consumed last cycle
  logic        active;        // Events allowed
  logic [15:0] wrap_top;      // Upper end of the count range

  // --------------------
  // Register writes
  // --------------------
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      cntr_ctrl <= ttc_pkg::CNTR_CTRL_RESET;
      interval  <= '0;
      match_1   <= '0;
      match_2   <= '0;
      match_3   <= '0;
    end
    else
    begin
      if (wr.cntr_ctrl)
        cntr_ctrl <= ttc_pkg::cntr_ctrl_t'(wr.data[ttc_pkg::CNTR_CTRL_W-1:0]);
      else if (restart_pend)
        cntr_ctrl.restart <= 1'b0;  // Self clear after use
      if (wr.interval)
        interval <= wr.data;
      if (wr.match_1)
        match_1 <= wr.data;
      if (wr.match_2)
        match_2 <= wr.data;
      if (wr.match_3)
        match_3 <= wr.data;
    end
  end

  assign wrap_top = cntr_ctrl.interval_mode ? interval : 16'hFFFF;

  // --------------------
  // Counter
  // --------------------
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
    begin
      count_val    <= '0;
      counting     <= 1'b0;
      restart_pend <= 1'b0;
    end
    else
    begin
      restart_pend <= count_en & cntr_ctrl.restart;  // One cycle only
      if (count_en)
      begin
        if (cntr_ctrl.restart)
        begin
          // Down counts start from the top of the range
          count_val <= cntr_ctrl.decrement ? wrap_top : 16'h0000;
          counting  <= 1'b0;
        end
        else if (!cntr_ctrl.cnt_disable)
        begin
          if (cntr_ctrl.decrement)
          begin
            if (count_val == 16'h0000)
              count_val <= wrap_top;      // Interval assumed static
            else
              count_val <= count_val - 16'h0001;
          end
          else
          begin
            if (count_val == wrap_top)
              count_val <= 16'h0000;
            else
              count_val <= count_val + 16'h0001;
          end
          counting <= 1'b1;
        end
      end
    end
  end

  // --------------------
  // Events
  // --------------------
  assign active = counting & ~cntr_ctrl.restart & ~cntr_ctrl.cnt_disable;

  assign events.interval = active & cntr_ctrl.interval_mode & (count_val == 16'h0000);
  assign events.overflow = active & ~cntr_ctrl.interval_mode & (count_val == 16'h0000);
  assign events.match[0] = active & cntr_ctrl.match_mode & (count_val == match_1);
  assign events.match[1] = active & cntr_ctrl.match_mode & (count_val == match_2);
  assign events.match[2] = active & cntr_ctrl.match_mode & (count_val == match_3);

  // Stays inside the interval once inside, while nothing is rewritten
  a_in_interval: assert property (
    @(posedge pclk14) disable iff (!n_p_reset14)
    (count_en && cntr_ctrl.interval_mode && !cntr_ctrl.cnt_disable && !cntr_ctrl.restart
     && (count_val <= interval) && !wr.interval && !wr.cntr_ctrl)
    |=> (count_val <= interval));

  // Restart is gone two cycles after the count_en that used it
  a_restart_clears: assert property (
    @(posedge pclk14) disable iff (!n_p_reset14)
    (count_en && cntr_ctrl.restart && !wr.cntr_ctrl) ##1 !wr.cntr_ctrl
    |=> !cntr_ctrl.restart);

endmodule

//--- source/ttc_prescaler.sv
/* Clock-control register and count-enable generator. count_en pulses once
   every 2^N cycles while enabled; N is the exponent field of CLK_CTRL. */
`timescale 1ns/10ps

module ttc_prescaler #(
  parameter int PRESCALE_W = 4  // Exponent field width
) (
  input  logic             pclk14,
  input  logic             n_p_reset14,
  input  ttc_pkg::reg_wr_t wr,
  output logic [15:0]      clk_ctrl,   // Read-back
  output logic             count_en
);

  localparam int DIV_W = (1 << PRESCALE_W) - 1;  // Enough bits for the largest N

  logic [PRESCALE_W:0]   clk_ctrl_q;  // Exponent over enable
  logic [PRESCALE_W-1:0] exp_n;
  logic [DIV_W-1:0]      div_q;       // Free-running divider
  logic [DIV_W-1:0]      div_mask;    // Low N bits set

  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
      clk_ctrl_q <= '0;
    else if (wr.clk_ctrl)
      clk_ctrl_q <= wr.data[PRESCALE_W:0];
  end

  assign clk_ctrl = 16'(clk_ctrl_q);  // Upper bits read as 0
  assign exp_n    = clk_ctrl_q[ttc_pkg::CLK_N_LSB +: PRESCALE_W];

  // Divider restarts from 0 on every CLK_CTRL write
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
      div_q <= '0;
    else if (wr.clk_ctrl)
      div_q <= '0;
    else
      div_q <= div_q + 1'b1;
  end

  // --------------------
  // Enable pulse
  // --------------------
  assign div_mask = ~({DIV_W{1'b1}} << exp_n);  // N = 0 gives an empty mask

  // Pulse when the low N bits wrap; every cycle for N = 0
  assign count_en = clk_ctrl_q[ttc_pkg::CLK_EN_BIT] & ((div_q & div_mask) == div_mask);

endmodule

//--- source/ttc_reg_decode.sv
/* Host side of the timer. Runs the valid/ready handshake, decodes the word
   address into write strobes and returns read data one cycle after acceptance. */
`timescale 1ns/10ps

module ttc_reg_decode (
  input  logic                pclk14,
  input  logic                n_p_reset14,
  // Request channel
  input  logic                req_valid,
  output logic                req_ready,
  input  ttc_pkg::bus_req_t   req,
  // Response channel
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output ttc_pkg::bus_rsp_t   rsp,
  // To the register owners
  output ttc_pkg::reg_wr_t    wr,
  output logic                status_rd,
  // Register values for read-back
  input  logic [15:0]         clk_ctrl,
  input  ttc_pkg::cntr_ctrl_t cntr_ctrl,
  input  logic [15:0]         interval,
  input  logic [15:0]         match_1,
  input  logic [15:0]         match_2,
  input  logic [15:0]         match_3,
  input  logic [15:0]         count_val,
  input  ttc_pkg::cnt_event_t status,
  input  ttc_pkg::cnt_event_t enable
);

  logic              accept;     // Request transfers this cycle
  logic              in_map;     // Address decodes to a register
  logic              read_only;  // COUNT_VAL or INTR_STATUS
  logic              bad_acc;    // Response carries err
  logic              wr_ok;      // Accepted write that lands
  logic [15:0]       rd_data;
  ttc_pkg::bus_rsp_t rsp_q;

  // One transaction in flight at most
  assign req_ready = ~rsp_valid;
  assign accept    = req_valid & req_ready;

  // --------------------
  // Address decode
  // --------------------
  always_comb
  begin
    rd_data   = '0;
    in_map    = 1'b1;
    read_only = 1'b0;
    case (req.addr)
      ttc_pkg::ADDR_CLK_CTRL:    rd_data = clk_ctrl;
      ttc_pkg::ADDR_CNTR_CTRL:   rd_data = 16'(cntr_ctrl);
      ttc_pkg::ADDR_INTERVAL:    rd_data = interval;
      ttc_pkg::ADDR_MATCH_1:     rd_data = match_1;
      ttc_pkg::ADDR_MATCH_2:     rd_data = match_2;
      ttc_pkg::ADDR_MATCH_3:     rd_data = match_3;
      ttc_pkg::ADDR_COUNT_VAL:
      begin
        rd_data   = count_val;
        read_only = 1'b1;
      end
      ttc_pkg::ADDR_INTR_STATUS:
      begin
        rd_data   = 16'(status);  // Pre-clear value
        read_only = 1'b1;
      end
      ttc_pkg::ADDR_INTR_ENABLE: rd_data = 16'(enable);
      default:                   in_map  = 1'b0;  // rdata stays 0
    endcase
  end

  assign bad_acc = ~in_map | (req.write & read_only);
  assign wr_ok   = accept & req.write & ~bad_acc;

  // Write strobes, single cycle
  always_comb
  begin
    wr             = '0;
    wr.data        = req.wdata;
    wr.clk_ctrl    = wr_ok & (req.addr == ttc_pkg::ADDR_CLK_CTRL);
    wr.cntr_ctrl   = wr_ok & (req.addr == ttc_pkg::ADDR_CNTR_CTRL);
    wr.interval    = wr_ok & (req.addr == ttc_pkg::ADDR_INTERVAL);
    wr.match_1     = wr_ok & (req.addr == ttc_pkg::ADDR_MATCH_1);
    wr.match_2     = wr_ok & (req.addr == ttc_pkg::ADDR_MATCH_2);
    wr.match_3     = wr_ok & (req.addr == ttc_pkg::ADDR_MATCH_3);
    wr.intr_enable = wr_ok & (req.addr == ttc_pkg::ADDR_INTR_ENABLE);
  end

  assign status_rd = accept & ~req.write & (req.addr == ttc_pkg::ADDR_INTR_STATUS);

  // --------------------
  // Response register
  // --------------------
  always_ff @(posedge pclk14 or negedge n_p_reset14)
  begin
    if (!n_p_reset14)
      rsp_valid <= 1'b0;
    else if (accept)
      rsp_valid <= 1'b1;
    else if (rsp_ready)
      rsp_valid <= 1'b0;  // Host took it
  end

  always_ff @(posedge pclk14)
  begin
    if (accept)
    begin
      rsp_q.rdata <= (req.write | bad_acc) ? 16'h0000 : rd_data;  // Writes return 0
      rsp_q.err   <= bad_acc;
    end
  end

  assign rsp = rsp_q;

  // Held response must not move under back-pressure
  a_rsp_stable: assert property (
    @(posedge pclk14) disable iff (!n_p_reset14)
    (rsp_valid && !rsp_ready) |=> $stable(rsp));

endmodule

//--- source/ttc_pkg.sv
/* Shared definitions for the timer: register map, host bus and strobe structs,
   counter control layout and event layout. Referenced by scoped names only. */

package ttc_pkg;

  // --------------------
  // Register map
  // --------------------
  typedef enum logic [3:0] {
    ADDR_CLK_CTRL    = 4'd0,  // Prescaler enable and exponent
    ADDR_CNTR_CTRL   = 4'd1,  // Counter control word
    ADDR_INTERVAL    = 4'd2,
    ADDR_MATCH_1     = 4'd3,
    ADDR_MATCH_2     = 4'd4,
    ADDR_MATCH_3     = 4'd5,
    ADDR_COUNT_VAL   = 4'd6,  // Read only
    ADDR_INTR_STATUS = 4'd7,  // Read only, clear-on-read
    ADDR_INTR_ENABLE = 4'd8
  } reg_addr_e;

  // --------------------
  // Host bus
  // --------------------
  typedef struct packed {
    logic        write;  // 1 = write, 0 = read
    logic [3:0]  addr;   // Word address, may lie outside the map
    logic [15:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [15:0] rdata;
    logic        err;    // Unmapped address or write to read-only
  } bus_rsp_t;

  // Write strobes, one-hot, valid on the acceptance cycle
  typedef struct packed {
    logic        clk_ctrl;
    logic        cntr_ctrl;
    logic        interval;
    logic        match_1;
    logic        match_2;
    logic        match_3;
    logic        intr_enable;
    logic [15:0] data;       // Shared write data
  } reg_wr_t;

  // --------------------
  // Counter control word
  // --------------------
  localparam int CNTR_CTRL_W = 7;

  typedef struct packed {
    logic wave_pol;       // Bit 6, stored only
    logic wave_n_en;      // Bit 5, stored only
    logic restart;        // Bit 4, self clearing
    logic match_mode;     // Bit 3
    logic decrement;      // Bit 2
    logic interval_mode;  // Bit 1, else full 16-bit range
    logic cnt_disable;    // Bit 0, high stops counting
  } cntr_ctrl_t;

  localparam cntr_ctrl_t CNTR_CTRL_RESET = cntr_ctrl_t'(7'b000_0001);  // Disabled

  // CLK_CTRL field positions
  localparam int CLK_EN_BIT = 0;
  localparam int CLK_N_LSB  = 1;  // Exponent N starts here

  // Event pulses; also the low bits of status and enable
  typedef struct packed {
    logic [2:0] match;     // Bits 4:2, match 3..1
    logic       overflow;  // Bit 1
    logic       interval;  // Bit 0
  } cnt_event_t;

  localparam int PRESCALE_W_DEF = 4;

endpackage
